/* src/axi_pkg.sv */
// Shared widths and channel structs; IDs have one width on both sides, bursts are word-wide INCR
`default_nettype none

package axi_pkg;

    // ----------------------------------------
    // Bus widths
    // ----------------------------------------
    localparam int unsigned id_bits   = 4;
    localparam int unsigned addr_bits = 32;
    localparam int unsigned data_bits = 32;
    localparam int unsigned strb_bits = 4;
    localparam int unsigned len_bits  = 4;

    localparam logic [1:0] resp_okay = 2'b00;

    // ----------------------------------------
    // Indices and directions
    // ----------------------------------------
    typedef enum logic {M0, M1} master_e;

    // NONE covers an idle valid and any address outside both windows
    typedef enum logic [1:0] {S0, S1, NONE} slave_e;

    typedef enum logic {READ, WRITE} xfer_e;

    // Ownership record of one subordinate
    typedef struct packed {
        logic    busy;
        xfer_e   dir;
        master_e owner;
    } slave_status_t;

    // ----------------------------------------
    // Channel payloads, ready travels apart
    // ----------------------------------------
    typedef struct packed {
        logic                 valid;
        logic [id_bits-1:0]   id;
        logic [addr_bits-1:0] addr;
        logic [len_bits-1:0]  len;
    } ar_t;

    typedef struct packed {
        logic                 valid;
        logic [id_bits-1:0]   id;
        logic [addr_bits-1:0] addr;
        logic [len_bits-1:0]  len;
    } aw_t;

    typedef struct packed {
        logic                 valid;
        logic [id_bits-1:0]   id;
        logic [data_bits-1:0] data;
        logic [1:0]           resp;
        logic                 last;
    } r_t;

    typedef struct packed {
        logic                 valid;
        logic [data_bits-1:0] data;
        logic [strb_bits-1:0] strb;
        logic                 last;
    } w_t;

    typedef struct packed {
        logic               valid;
        logic [id_bits-1:0] id;
        logic [1:0]         resp;
    } b_t;

endpackage

`default_nettype wire

/* src/axi_addr_decoder.sv */
// Combinational decode into two inclusive windows; an address outside both gives NONE
`default_nettype none

module axi_addr_decoder #(
    parameter logic [axi_pkg::addr_bits-1:0] S0_BASE = 32'h0000_0000,
    parameter logic [axi_pkg::addr_bits-1:0] S0_LAST = 32'h0000_FFFF,
    parameter logic [axi_pkg::addr_bits-1:0] S1_BASE = 32'h0001_0000,
    parameter logic [axi_pkg::addr_bits-1:0] S1_LAST = 32'h0001_FFFF
) (
    input  axi_pkg::ar_t   m0_ar,
    input  axi_pkg::ar_t   m1_ar,
    input  axi_pkg::aw_t   m1_aw,
    output axi_pkg::slave_e m0_rd_target,
    output axi_pkg::slave_e m1_rd_target,
    output axi_pkg::slave_e m1_wr_target
);

    // Target of one request, NONE while valid is low
    function automatic axi_pkg::slave_e decode(
        input logic                          valid,
        input logic [axi_pkg::addr_bits-1:0] addr
    );
        if (!valid) begin
            return axi_pkg::NONE;
        end
        if (addr >= S0_BASE && addr <= S0_LAST) begin
            return axi_pkg::S0;
        end
        if (addr >= S1_BASE && addr <= S1_LAST) begin
            return axi_pkg::S1;
        end
        return axi_pkg::NONE;
    endfunction

    always_comb begin
        m0_rd_target = decode(m0_ar.valid, m0_ar.addr);
        m1_rd_target = decode(m1_ar.valid, m1_ar.addr);
        m1_wr_target = decode(m1_aw.valid, m1_aw.addr);
    end

endmodule

`default_nettype wire

/* src/axi_slave_arbiter.sv */
// Priority flips every cycle; a subordinate is relocked on the edge that ends its transaction
`default_nettype none

module axi_slave_arbiter (
    input  logic                   ACLK,
    input  logic                   ARESETn,
    input  axi_pkg::slave_e        m0_rd_target,
    input  axi_pkg::slave_e        m1_rd_target,
    input  axi_pkg::slave_e        m1_wr_target,
    input  logic                   s0_done,
    input  logic                   s1_done,
    output axi_pkg::slave_status_t s0_status,
    output axi_pkg::slave_status_t s1_status
);

    axi_pkg::master_e       prio;
    axi_pkg::slave_status_t s0_win;
    axi_pkg::slave_status_t s1_win;
    axi_pkg::slave_status_t s0_next;
    axi_pkg::slave_status_t s1_next;

    // ----------------------------------------
    // Winner among requests aimed at one target
    // ----------------------------------------
    // busy in the result means some request exists
    function automatic axi_pkg::slave_status_t pick_winner(
        input axi_pkg::slave_e  who,
        input axi_pkg::master_e favored,
        input axi_pkg::slave_e  m0_rd,
        input axi_pkg::slave_e  m1_rd,
        input axi_pkg::slave_e  m1_wr
    );
        axi_pkg::slave_status_t win;
        logic m0_req;
        logic m1_rd_req;
        logic m1_wr_req;
        m0_req    = (m0_rd == who);
        m1_rd_req = (m1_rd == who);
        m1_wr_req = (m1_wr == who);
        win       = '0;
        if (m0_req && (favored == axi_pkg::M0 || !(m1_wr_req || m1_rd_req))) begin
            win.busy  = 1'b1;
            win.dir   = axi_pkg::READ;
            win.owner = axi_pkg::M0;
        end else if (m1_wr_req) begin
            // M1 write beats M1 read
            win.busy  = 1'b1;
            win.dir   = axi_pkg::WRITE;
            win.owner = axi_pkg::M1;
        end else if (m1_rd_req) begin
            win.busy  = 1'b1;
            win.dir   = axi_pkg::READ;
            win.owner = axi_pkg::M1;
        end
        return win;
    endfunction

    // Idle or finishing subordinate takes the winner, or goes idle if there is none.
    // Same owner and direction as the finishing one gives the hold case.
    function automatic axi_pkg::slave_status_t next_status(
        input axi_pkg::slave_status_t cur,
        input axi_pkg::slave_status_t win,
        input logic                   done
    );
        if (!cur.busy || done) begin
            return win;
        end
        return cur;
    endfunction

    always_comb begin
        s0_win  = pick_winner(axi_pkg::S0, prio, m0_rd_target, m1_rd_target, m1_wr_target);
        s1_win  = pick_winner(axi_pkg::S1, prio, m0_rd_target, m1_rd_target, m1_wr_target);
        s0_next = next_status(s0_status, s0_win, s0_done);
        s1_next = next_status(s1_status, s1_win, s1_done);
    end

    // ----------------------------------------
    // State registers
    // ----------------------------------------
    always_ff @(posedge ACLK or negedge ARESETn) begin
        if (!ARESETn) begin
            prio      <= axi_pkg::M0;
            s0_status <= '0;
            s1_status <= '0;
        end else begin
            prio      <= (prio == axi_pkg::M0) ? axi_pkg::M1 : axi_pkg::M0;
            s0_status <= s0_next;
            s1_status <= s1_next;
        end
    end

endmodule

`default_nettype wire

/* src/axi_read_mux.sv */
// AR and R steering for one subordinate; outputs are zero unless it is locked for a read
`default_nettype none

module axi_read_mux (
    input  axi_pkg::slave_status_t status,
    input  axi_pkg::ar_t           m0_ar,
    input  axi_pkg::ar_t           m1_ar,
    input  logic                   m0_r_ready,
    input  logic                   m1_r_ready,
    input  logic                   s_ar_ready,
    input  axi_pkg::r_t            s_r,
    output axi_pkg::ar_t           s_ar,
    output logic                   s_r_ready,
    output logic                   m0_ar_ready,
    output logic                   m1_ar_ready,
    output axi_pkg::r_t            m0_r,
    output axi_pkg::r_t            m1_r,
    output logic                   done
);

    logic read_owned;

    assign read_owned = status.busy && (status.dir == axi_pkg::READ);

    // ----------------------------------------
    // Crossbar paths
    // ----------------------------------------
    always_comb begin
        // Zero so the top level can OR both muxes together
        s_ar        = '0;
        s_r_ready   = 1'b0;
        m0_ar_ready = 1'b0;
        m1_ar_ready = 1'b0;
        m0_r        = '0;
        m1_r        = '0;

        if (read_owned) begin
            case (status.owner)
                axi_pkg::M0: begin
                    // Owner M0
                    s_ar        = m0_ar;
                    m0_ar_ready = s_ar_ready;
                    m0_r        = s_r;
                    s_r_ready   = m0_r_ready;
                end
                axi_pkg::M1: begin
                    s_ar        = m1_ar;
                    m1_ar_ready = s_ar_ready;
                    m1_r        = s_r;
                    s_r_ready   = m1_r_ready;
                end
            endcase
        end
    end

    // Last R beat accepted by the owner ends the burst
    assign done = s_r.valid && s_r_ready && s_r.last;

endmodule

`default_nettype wire

/* src/axi_write_mux.sv */
// AW, W and B steering for one subordinate; only manager 1 writes, zero unless locked for it
`default_nettype none

module axi_write_mux (
    input  axi_pkg::slave_status_t status,
    input  axi_pkg::aw_t           m1_aw,
    input  axi_pkg::w_t            m1_w,
    input  logic                   m1_b_ready,
    input  logic                   s_aw_ready,
    input  logic                   s_w_ready,
    input  axi_pkg::b_t            s_b,
    output axi_pkg::aw_t           s_aw,
    output axi_pkg::w_t            s_w,
    output logic                   s_b_ready,
    output logic                   m1_aw_ready,
    output logic                   m1_w_ready,
    output axi_pkg::b_t            m1_b,
    output logic                   done
);

    logic write_owned;

    assign write_owned = status.busy
                      && (status.dir == axi_pkg::WRITE)
                      && (status.owner == axi_pkg::M1);

    // ----------------------------------------
    // Crossbar paths
    // ----------------------------------------
    always_comb begin
        s_aw        = '0;
        s_w         = '0;
        s_b_ready   = 1'b0;
        m1_aw_ready = 1'b0;
        m1_w_ready  = 1'b0;
        m1_b        = '0;

        if (write_owned) begin
            // Address and data go down together
            s_aw        = m1_aw;
            m1_aw_ready = s_aw_ready;
            s_w         = m1_w;
            m1_w_ready  = s_w_ready;
            // Response back to M1
            m1_b        = s_b;
            s_b_ready   = m1_b_ready;
        end
    end

    // B handshake ends the write
    assign done = s_b.valid && s_b_ready;

endmodule

`default_nettype wire

/* src/axi_crossbar.sv */
// 2x2 AXI crossbar, M0 read only; no buffering, a stalled R or B holds the subordinate locked
`default_nettype none

module axi_crossbar #(
    parameter logic [axi_pkg::addr_bits-1:0] S0_BASE = 32'h0000_0000,
    parameter logic [axi_pkg::addr_bits-1:0] S0_LAST = 32'h0000_FFFF,
    parameter logic [axi_pkg::addr_bits-1:0] S1_BASE = 32'h0001_0000,
    parameter logic [axi_pkg::addr_bits-1:0] S1_LAST = 32'h0001_FFFF
) (
    input  logic         ACLK,
    input  logic         ARESETn,
    // Manager side
    input  axi_pkg::ar_t m0_ar,
    input  axi_pkg::ar_t m1_ar,
    input  axi_pkg::aw_t m1_aw,
    input  axi_pkg::w_t  m1_w,
    input  logic         m0_r_ready,
    input  logic         m1_r_ready,
    input  logic         m1_b_ready,
    output logic         m0_ar_ready,
    output logic         m1_ar_ready,
    output logic         m1_aw_ready,
    output logic         m1_w_ready,
    output axi_pkg::r_t  m0_r,
    output axi_pkg::r_t  m1_r,
    output axi_pkg::b_t  m1_b,
    // Subordinate 0
    output axi_pkg::ar_t s0_ar,
    output axi_pkg::aw_t s0_aw,
    output axi_pkg::w_t  s0_w,
    output logic         s0_r_ready,
    output logic         s0_b_ready,
    input  logic         s0_ar_ready,
    input  logic         s0_aw_ready,
    input  logic         s0_w_ready,
    input  axi_pkg::r_t  s0_r,
    input  axi_pkg::b_t  s0_b,
    // Subordinate 1
    output axi_pkg::ar_t s1_ar,
    output axi_pkg::aw_t s1_aw,
    output axi_pkg::w_t  s1_w,
    output logic         s1_r_ready,
    output logic         s1_b_ready,
    input  logic         s1_ar_ready,
    input  logic         s1_aw_ready,
    input  logic         s1_w_ready,
    input  axi_pkg::r_t  s1_r,
    input  axi_pkg::b_t  s1_b
);

    axi_pkg::slave_e        m0_rd_target;
    axi_pkg::slave_e        m1_rd_target;
    axi_pkg::slave_e        m1_wr_target;
    axi_pkg::slave_status_t s0_status;
    axi_pkg::slave_status_t s1_status;

    // Per-subordinate contributions, merged below
    logic        s0_rd_done, s1_rd_done, s0_wr_done, s1_wr_done;
    logic        s0_m0_ar_ready, s1_m0_ar_ready, s0_m1_ar_ready, s1_m1_ar_ready;
    logic        s0_m1_aw_ready, s1_m1_aw_ready, s0_m1_w_ready, s1_m1_w_ready;
    axi_pkg::r_t s0_m0_r, s1_m0_r, s0_m1_r, s1_m1_r;
    axi_pkg::b_t s0_m1_b, s1_m1_b;

    axi_addr_decoder #(
        .S0_BASE (S0_BASE),
        .S0_LAST (S0_LAST),
        .S1_BASE (S1_BASE),
        .S1_LAST (S1_LAST)
    ) u_decoder (
        .m0_ar (m0_ar), .m1_ar (m1_ar), .m1_aw (m1_aw),
        .m0_rd_target (m0_rd_target),
        .m1_rd_target (m1_rd_target),
        .m1_wr_target (m1_wr_target)
    );

    axi_slave_arbiter u_arbiter (
        .ACLK (ACLK), .ARESETn (ARESETn),
        .m0_rd_target (m0_rd_target),
        .m1_rd_target (m1_rd_target),
        .m1_wr_target (m1_wr_target),
        .s0_done   (s0_rd_done | s0_wr_done),
        .s1_done   (s1_rd_done | s1_wr_done),
        .s0_status (s0_status),
        .s1_status (s1_status)
    );

    // ----------------------------------------
    // Per-subordinate muxes
    // ----------------------------------------
    axi_read_mux u_s0_rd (
        .status (s0_status), .m0_ar (m0_ar), .m1_ar (m1_ar),
        .m0_r_ready (m0_r_ready), .m1_r_ready (m1_r_ready),
        .s_ar_ready (s0_ar_ready), .s_r (s0_r), .s_ar (s0_ar), .s_r_ready (s0_r_ready),
        .m0_ar_ready (s0_m0_ar_ready), .m1_ar_ready (s0_m1_ar_ready),
        .m0_r (s0_m0_r), .m1_r (s0_m1_r), .done (s0_rd_done)
    );

    axi_read_mux u_s1_rd (
        .status (s1_status), .m0_ar (m0_ar), .m1_ar (m1_ar),
        .m0_r_ready (m0_r_ready), .m1_r_ready (m1_r_ready),
        .s_ar_ready (s1_ar_ready), .s_r (s1_r), .s_ar (s1_ar), .s_r_ready (s1_r_ready),
        .m0_ar_ready (s1_m0_ar_ready), .m1_ar_ready (s1_m1_ar_ready),
        .m0_r (s1_m0_r), .m1_r (s1_m1_r), .done (s1_rd_done)
    );

    axi_write_mux u_s0_wr (
        .status (s0_status), .m1_aw (m1_aw), .m1_w (m1_w), .m1_b_ready (m1_b_ready),
        .s_aw_ready (s0_aw_ready), .s_w_ready (s0_w_ready), .s_b (s0_b),
        .s_aw (s0_aw), .s_w (s0_w), .s_b_ready (s0_b_ready),
        .m1_aw_ready (s0_m1_aw_ready), .m1_w_ready (s0_m1_w_ready),
        .m1_b (s0_m1_b), .done (s0_wr_done)
    );

    axi_write_mux u_s1_wr (
        .status (s1_status), .m1_aw (m1_aw), .m1_w (m1_w), .m1_b_ready (m1_b_ready),
        .s_aw_ready (s1_aw_ready), .s_w_ready (s1_w_ready), .s_b (s1_b),
        .s_aw (s1_aw), .s_w (s1_w), .s_b_ready (s1_b_ready),
        .m1_aw_ready (s1_m1_aw_ready), .m1_w_ready (s1_m1_w_ready),
        .m1_b (s1_m1_b), .done (s1_wr_done)
    );

    // Non-owning mux drives zero, so OR picks the owner
    assign m0_ar_ready = s0_m0_ar_ready | s1_m0_ar_ready;
    assign m1_ar_ready = s0_m1_ar_ready | s1_m1_ar_ready;
    assign m1_aw_ready = s0_m1_aw_ready | s1_m1_aw_ready;
    assign m1_w_ready  = s0_m1_w_ready | s1_m1_w_ready;
    assign m0_r        = s0_m0_r | s1_m0_r;
    assign m1_r        = s0_m1_r | s1_m1_r;
    assign m1_b        = s0_m1_b | s1_m1_b;

endmodule

`default_nettype wire

/* test/tb_clock_gen.sv */
// Testbench clock with period 4 and reset held low for the first 10 rising edges
`default_nettype none

module tb_clock_gen (
    output logic ACLK,
    output logic ARESETn
);

    initial begin
        ACLK = 1'b0;
        forever #2 ACLK = ~ACLK;
    end

    // Release away from the rising edge
    initial begin
        ARESETn = 1'b0;
        repeat (10) @(posedge ACLK);
        @(negedge ACLK);
        ARESETn = 1'b1;
    end

endmodule

`default_nettype wire

/* test/tb_slave_model.sv */
// Behavioral subordinate, word-wide INCR bursts only; unwritten words read as address XOR A5A5A5A5
`default_nettype none

module tb_slave_model #(
    parameter logic [31:0] BASE = 32'h0000_0000
) (
    input  logic         ACLK,
    input  logic         ARESETn,
    input  axi_pkg::ar_t ar,
    output logic         ar_ready,
    output axi_pkg::r_t  r,
    input  logic         r_ready,
    input  axi_pkg::aw_t aw,
    output logic         aw_ready,
    input  axi_pkg::w_t  w,
    output logic         w_ready,
    output axi_pkg::b_t  b,
    input  logic         b_ready,
    output logic         stray
);

    typedef enum logic [1:0] {IDLE, RD, WR_DATA, WR_RESP} state_e;

    state_e      st;
    logic [31:0] mem [logic [31:0]];
    logic [31:0] addr;
    logic [3:0]  left;
    logic [3:0]  id;
    int          wait_cnt;

    function automatic logic [31:0] word_at(input logic [31:0] a);
        if (mem.exists(a)) begin
            return mem[a];
        end
        return a ^ 32'hA5A5_A5A5;
    endfunction

    function automatic logic [31:0] merge(
        input logic [31:0] old,
        input logic [31:0] d,
        input logic [3:0]  s
    );
        logic [31:0] res;
        res = old;
        for (int i = 0; i < 4; i++) begin
            if (s[i]) begin
                res[8*i +: 8] = d[8*i +: 8];
            end
        end
        return res;
    endfunction

    always @(posedge ACLK or negedge ARESETn) begin
        if (!ARESETn) begin
            st       <= IDLE;
            ar_ready <= 1'b0;
            aw_ready <= 1'b0;
            w_ready  <= 1'b0;
            r        <= '0;
            b        <= '0;
            addr     <= '0;
            left     <= '0;
            id       <= '0;
            wait_cnt <= 0;
            stray    <= 1'b0;
        end else begin
            case (st)
                IDLE: begin
                    if (ar.valid && ar_ready) begin
                        ar_ready <= 1'b0;
                        addr     <= ar.addr;
                        left     <= ar.len;
                        id       <= ar.id;
                        wait_cnt <= $urandom % 3;
                        st       <= RD;
                        if (ar.addr - BASE > 32'h0000_FFFF) begin
                            stray <= 1'b1;
                        end
                    end else if (aw.valid && aw_ready) begin
                        aw_ready <= 1'b0;
                        addr     <= aw.addr;
                        id       <= aw.id;
                        w_ready  <= 1'b1;
                        st       <= WR_DATA;
                        if (aw.addr - BASE > 32'h0000_FFFF) begin
                            stray <= 1'b1;
                        end
                    end else if (ar.valid || aw.valid) begin
                        // Random accept delay
                        if (wait_cnt == 0) begin
                            ar_ready <= ar.valid;
                            aw_ready <= !ar.valid;
                        end else begin
                            wait_cnt <= wait_cnt - 1;
                        end
                    end else begin
                        wait_cnt <= $urandom % 4;
                    end
                end
                RD: begin
                    if (r.valid && r_ready) begin
                        r.valid  <= 1'b0;
                        addr     <= addr + 32'd4;
                        left     <= left - 1'b1;
                        wait_cnt <= $urandom % 3;
                        if (r.last) begin
                            st <= IDLE;
                        end
                    end else if (!r.valid) begin
                        if (wait_cnt == 0) begin
                            r.valid <= 1'b1;
                            r.id    <= id;
                            r.data  <= word_at(addr);
                            r.resp  <= axi_pkg::resp_okay;
                            r.last  <= (left == 0);
                        end else begin
                            wait_cnt <= wait_cnt - 1;
                        end
                    end
                end
                WR_DATA: begin
                    if (w.valid && w_ready) begin
                        mem[addr] = merge(word_at(addr), w.data, w.strb);
                        addr <= addr + 32'd4;
                        if (w.last) begin
                            w_ready <= 1'b0;
                            b.valid <= 1'b1;
                            b.id    <= id;
                            b.resp  <= axi_pkg::resp_okay;
                            st      <= WR_RESP;
                        end
                    end
                end
                default: begin
                    if (b.valid && b_ready) begin
                        b.valid <= 1'b0;
                        st      <= IDLE;
                    end
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* test/tb_axi_crossbar.sv */
// Runs vector groups with one operation per manager at a time; write beat i carries data plus i*01010101
`default_nettype none

module tb_axi_crossbar;

    typedef struct {
        int          grp;
        int          mgr;
        int          dir;
        logic [31:0] addr;
        logic [3:0]  len;
        logic [3:0]  id;
        logic [31:0] data;
        logic [3:0]  strb;
    } vec_t;

    logic ACLK;
    logic ARESETn;

    axi_pkg::ar_t m0_ar, m1_ar, s0_ar, s1_ar;
    axi_pkg::aw_t m1_aw, s0_aw, s1_aw;
    axi_pkg::w_t  m1_w, s0_w, s1_w;
    axi_pkg::r_t  m0_r, m1_r, s0_r, s1_r;
    axi_pkg::b_t  m1_b, s0_b, s1_b;
    logic m0_r_ready, m1_r_ready, m1_b_ready;
    logic m0_ar_ready, m1_ar_ready, m1_aw_ready, m1_w_ready;
    logic s0_r_ready, s0_b_ready, s0_ar_ready, s0_aw_ready, s0_w_ready, s0_stray;
    logic s1_r_ready, s1_b_ready, s1_ar_ready, s1_aw_ready, s1_w_ready, s1_stray;

    vec_t        vecs[$];
    int          n_vec;
    logic [31:0] shadow [logic [31:0]];

    // ID of the read each manager has open
    logic [3:0]  m0_rd_id;
    logic [3:0]  m1_rd_id;

    tb_clock_gen u_clk (.ACLK (ACLK), .ARESETn (ARESETn));

    axi_crossbar DUT (
        .ACLK (ACLK), .ARESETn (ARESETn),
        .m0_ar (m0_ar), .m1_ar (m1_ar), .m1_aw (m1_aw), .m1_w (m1_w),
        .m0_r_ready (m0_r_ready), .m1_r_ready (m1_r_ready), .m1_b_ready (m1_b_ready),
        .m0_ar_ready (m0_ar_ready), .m1_ar_ready (m1_ar_ready),
        .m1_aw_ready (m1_aw_ready), .m1_w_ready (m1_w_ready),
        .m0_r (m0_r), .m1_r (m1_r), .m1_b (m1_b),
        .s0_ar (s0_ar), .s0_aw (s0_aw), .s0_w (s0_w),
        .s0_r_ready (s0_r_ready), .s0_b_ready (s0_b_ready),
        .s0_ar_ready (s0_ar_ready), .s0_aw_ready (s0_aw_ready), .s0_w_ready (s0_w_ready),
        .s0_r (s0_r), .s0_b (s0_b),
        .s1_ar (s1_ar), .s1_aw (s1_aw), .s1_w (s1_w),
        .s1_r_ready (s1_r_ready), .s1_b_ready (s1_b_ready),
        .s1_ar_ready (s1_ar_ready), .s1_aw_ready (s1_aw_ready), .s1_w_ready (s1_w_ready),
        .s1_r (s1_r), .s1_b (s1_b)
    );

    tb_slave_model #(.BASE (32'h0000_0000)) u_s0 (
        .ACLK (ACLK), .ARESETn (ARESETn),
        .ar (s0_ar), .ar_ready (s0_ar_ready), .r (s0_r), .r_ready (s0_r_ready),
        .aw (s0_aw), .aw_ready (s0_aw_ready), .w (s0_w), .w_ready (s0_w_ready),
        .b (s0_b), .b_ready (s0_b_ready), .stray (s0_stray)
    );

    tb_slave_model #(.BASE (32'h0001_0000)) u_s1 (
        .ACLK (ACLK), .ARESETn (ARESETn),
        .ar (s1_ar), .ar_ready (s1_ar_ready), .r (s1_r), .r_ready (s1_r_ready),
        .aw (s1_aw), .aw_ready (s1_aw_ready), .w (s1_w), .w_ready (s1_w_ready),
        .b (s1_b), .b_ready (s1_b_ready), .stray (s1_stray)
    );

    // ----------------------------------------
    // Reference memory and checking
    // ----------------------------------------
    function automatic logic [31:0] expect_word(input logic [31:0] a);
        if (shadow.exists(a)) begin
            return shadow[a];
        end
        return a ^ 32'hA5A5_A5A5;
    endfunction

    task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            $display("mismatch %s expected %h actual %h", name, exp, act);
            $display("** FAIL **");
            $fatal(1);
        end
    endtask

    // Managers toggle ready at random
    function automatic logic random_ready();
        return ($urandom % 4) != 0;
    endfunction

    task automatic do_read(input int k);
        vec_t         v;
        axi_pkg::ar_t req;
        axi_pkg::r_t  rb;
        logic         got;
        logic         rdy;
        int           beat;
        string        name;
        v         = vecs[k];
        name      = $sformatf("op%0d", k);
        if (v.mgr == 0) begin
            m0_rd_id = v.id;
        end else begin
            m1_rd_id = v.id;
        end
        req.valid = 1'b1;
        req.id    = v.id;
        req.addr  = v.addr;
        req.len   = v.len;
        @(negedge ACLK);
        if (v.mgr == 0) m0_ar = req;
        else m1_ar = req;
        got = 1'b0;
        while (!got) begin
            #1;
            got = (v.mgr == 0) ? m0_ar_ready : m1_ar_ready;
            @(negedge ACLK);
        end
        if (v.mgr == 0) m0_ar = '0;
        else m1_ar = '0;
        beat = 0;
        got  = 1'b0;
        while (!got) begin
            rdy = random_ready();
            if (v.mgr == 0) m0_r_ready = rdy;
            else m1_r_ready = rdy;
            #1;
            rb = (v.mgr == 0) ? m0_r : m1_r;
            if (rdy && rb.valid) begin
                check_value({name, "_id"}, v.id, rb.id);
                check_value({name, "_resp"}, axi_pkg::resp_okay, rb.resp);
                check_value({name, "_last"}, beat == v.len, rb.last);
                check_value({name, "_data"}, expect_word(v.addr + 4 * beat), rb.data);
                if (beat == 0) begin
                    check_value({name, "_first"}, v.data, rb.data);
                end
                got  = rb.last;
                beat = beat + 1;
            end
            @(negedge ACLK);
        end
        if (v.mgr == 0) m0_r_ready = 1'b0;
        else m1_r_ready = 1'b0;
    endtask

    task automatic do_write(input int k);
        vec_t        v;
        logic        got;
        logic [31:0] d;
        logic [31:0] a;
        string       name;
        v    = vecs[k];
        name = $sformatf("op%0d", k);
        @(negedge ACLK);
        m1_aw.valid = 1'b1;
        m1_aw.id    = v.id;
        m1_aw.addr  = v.addr;
        m1_aw.len   = v.len;
        got = 1'b0;
        while (!got) begin
            #1;
            got = m1_aw_ready;
            @(negedge ACLK);
        end
        m1_aw = '0;
        for (int beat = 0; beat <= v.len; beat++) begin
            d      = v.data + 32'h0101_0101 * beat;
            a      = v.addr + 4 * beat;
            m1_w   = {1'b1, d, v.strb, beat == v.len};
            got    = 1'b0;
            while (!got) begin
                #1;
                got = m1_w_ready;
                @(negedge ACLK);
            end
            for (int i = 0; i < 4; i++) begin
                if (v.strb[i]) begin
                    shadow[a] = expect_word(a);
                    shadow[a][8*i +: 8] = d[8*i +: 8];
                end
            end
        end
        m1_w = '0;
        got  = 1'b0;
        while (!got) begin
            m1_b_ready = random_ready();
            #1;
            if (m1_b_ready && m1_b.valid) begin
                check_value({name, "_bid"}, v.id, m1_b.id);
                check_value({name, "_bresp"}, axi_pkg::resp_okay, m1_b.resp);
                got = 1'b1;
            end
            @(negedge ACLK);
        end
        m1_b_ready = 1'b0;
    endtask

    task automatic run_op(input int k);
        if (vecs[k].dir == 0) begin
            do_read(k);
        end else begin
            do_write(k);
        end
    endtask

    // ----------------------------------------
    // Main sequence
    // ----------------------------------------
    initial begin
        int          fd;
        int          cnt;
        int          g, m, d, k, i0, i1;
        logic [31:0] a, dt;
        logic [3:0]  l, id, s;
        string       line;
        vec_t        v;
        void'($urandom(32'h3af8_c7e8));
        n_vec      = 0;
        m0_ar      = '0;
        m1_ar      = '0;
        m1_aw      = '0;
        m1_w       = '0;
        m0_r_ready = 1'b0;
        m1_r_ready = 1'b0;
        m1_b_ready = 1'b0;
        m0_rd_id   = '0;
        m1_rd_id   = '0;
        fd = $fopen("test/axi_crossbar_vectors.txt", "r");
        if (fd == 0) begin
            $display("could not open the vectors file");
            $display("** FAIL **");
            $fatal(1);
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() > 1 && line.getc(0) != "#") begin
                cnt = $sscanf(line, "%d %d %d %h %h %h %h %h", g, m, d, a, l, id, dt, s);
                if (cnt == 8) begin
                    v = '{g, m, d, a, l, id, dt, s};
                    vecs.push_back(v);
                end
            end
        end
        $fclose(fd);
        n_vec = vecs.size();
        if (n_vec == 0) begin
            $display("the vectors file holds no operations");
            $display("** FAIL **");
            $fatal(1);
        end

        wait (ARESETn === 1'b1);
        // Idle outputs after reset
        repeat (5) begin
            @(negedge ACLK);
            #1;
            check_value("reset_idle", 32'd0,
                {m0_ar_ready, m1_ar_ready, m1_aw_ready, m1_w_ready, m0_r.valid, m1_r.valid,
                 m1_b.valid, s0_ar.valid, s0_aw.valid, s0_w.valid, s1_ar.valid,
                 s1_aw.valid, s1_w.valid, s0_r_ready, s0_b_ready, s1_r_ready,
                 s1_b_ready});
        end

        k = 0;
        while (k < n_vec) begin
            i0 = -1;
            i1 = -1;
            g  = vecs[k].grp;
            while (k < n_vec && vecs[k].grp == g) begin
                if (vecs[k].mgr == 0) i0 = k;
                else i1 = k;
                k = k + 1;
            end
            fork
                begin
                    if (i0 >= 0) run_op(i0);
                end
                begin
                    if (i1 >= 0) run_op(i1);
                end
            join
        end
        check_value("s0_stray", 32'd0, s0_stray);
        check_value("s1_stray", 32'd0, s1_stray);
        $display("** PASS **");
        $finish;
    end

    // Any R beat at a manager must belong to the read it issued
    initial begin
        forever begin
            @(negedge ACLK);
            #1;
            if (m0_r.valid) begin
                check_value("m0_r_route", m0_rd_id, m0_r.id);
            end
            if (m1_r.valid) begin
                check_value("m1_r_route", m1_rd_id, m1_r.id);
            end
        end
    end

    // Watchdog sized by the vector count
    initial begin
        wait (n_vec > 0);
        #(n_vec * 200 * 4);
        $display("timeout: the operations did not complete in time");
        $display("** FAIL **");
        $fatal(1);
    end

endmodule

`default_nettype wire

/* test/axi_crossbar_vectors.txt */
# group mgr dir(0 read, 1 write) addr len id data strb, all but the first three in hex
# data is the expected first read word, or the first write word; same group runs in parallel
1 0 0 00000100 0 3 a5a5a4a5 f
2 1 0 00010200 0 9 a5a4a7a5 f
3 1 1 00010400 3 5 11110000 6
4 1 0 00010400 3 6 a51100a5 f
5 0 0 00000200 2 1 a5a5a7a5 f
5 1 0 00000300 1 c a5a5a6a5 f
6 0 0 00000400 3 2 a5a5a1a5 f
6 1 1 00010800 2 7 22334455 f
7 0 0 00010900 1 4 a5a4aca5 f
7 1 0 00010800 2 8 22334455 f
8 0 0 00010000 0 e a5a4a5a5 f
8 1 1 00000800 1 a deadbeef 9
9 0 0 00000800 1 b dea5adef f
10 1 0 00010400 3 d a51100a5 f

/* sim.f */
src/axi_pkg.sv
src/axi_addr_decoder.sv
src/axi_slave_arbiter.sv
src/axi_read_mux.sv
src/axi_write_mux.sv
src/axi_crossbar.sv
test/tb_clock_gen.sv
test/tb_slave_model.sv
test/tb_axi_crossbar.sv

/* Bender.yml */
package:
  name: axi_crossbar

sources:
  - src/axi_pkg.sv
  - src/axi_addr_decoder.sv
  - src/axi_slave_arbiter.sv
  - src/axi_read_mux.sv
  - src/axi_write_mux.sv
  - src/axi_crossbar.sv
  - target: test
    files:
      - test/tb_clock_gen.sv
      - test/tb_slave_model.sv
      - test/tb_axi_crossbar.sv
